// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rtl/rv_pkg.sv
  - rtl/rv_decode.sv
  - rtl/rv_regfile.sv
  - rtl/rv_alu.sv
  - rtl/rv_pc_unit.sv
  - rtl/rv_control.sv
  - rtl/rv_core.sv
  - target: test
    files:
      - tb/rv_core_assert.sv
      - tb/rv_core_tb.sv

// ==== flist.f ====
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_pc_unit.sv
rtl/rv_control.sv
rtl/rv_core.sv
tb/rv_core_assert.sv
tb/rv_core_tb.sv

// ==== rtl/rv_alu.sv ====
// Combinational RV32I ALU and branch comparator.
// The result follows op; branch_taken evaluates the funct3 condition
// on the same two operands.

`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_pkg::alu_op_e         op,
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,
    input  logic [2:0]              funct3,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic                    branch_taken
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign eq    = a == b;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {{(XLEN-1){1'b0}}, lt_s};
            SLTU:    result = {{(XLEN-1){1'b0}}, lt_u};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = $unsigned($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            PASS_B:  result = b;
            default: result = '0;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  branch_taken = eq;
            F3_BNE:  branch_taken = !eq;
            F3_BLT:  branch_taken = lt_s;
            F3_BGE:  branch_taken = !lt_s;
            F3_BLTU: branch_taken = lt_u;
            F3_BGEU: branch_taken = !lt_u;
            // funct3 2 and 3 are reserved for branches
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_control.sv ====
// Core sequencer. Issues the fetch, executes on the fetch acknowledge,
// waits in MEM_WAIT for load and store data, and stops in HALTED.
// Also drives the memory port, the register write and the output strobe.

`timescale 1ns/1ps
`default_nettype none

module rv_control #(
    parameter logic [rv_pkg::ADDR_W-1:0] OUT_ADDR  = 32'd1000,
    parameter logic [rv_pkg::ADDR_W-1:0] HALT_ADDR = 32'd1004
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         mem_ack,
    input  rv_pkg::opcode_e              opcode,
    input  logic                         imm_valid_op,
    input  logic [rv_pkg::REG_SEL_W-1:0] rd,
    input  logic [rv_pkg::XLEN-1:0]      alu_result,
    input  logic [rv_pkg::XLEN-1:0]      rs2_data,
    input  logic [rv_pkg::XLEN-1:0]      mem_rd_data,
    input  logic [rv_pkg::ADDR_W-1:0]    next_pc,
    input  logic [rv_pkg::ADDR_W-1:0]    link_addr,
    output logic [rv_pkg::ADDR_W-1:0]    mem_addr,
    output logic [rv_pkg::XLEN-1:0]      mem_wr_data,
    output logic                         mem_rd_req,
    output logic                         mem_wr_req,
    output logic                         capture,
    output logic                         use_latched,
    output logic                         pc_load,
    output logic                         wr_en,
    output logic [rv_pkg::REG_SEL_W-1:0] wr_sel,
    output logic [rv_pkg::XLEN-1:0]      wr_data,
    output logic [rv_pkg::XLEN-1:0]      out,
    output logic                         outen,
    output logic                         halt
);
    import rv_pkg::*;

    typedef enum logic [1:0] {FETCH, EXEC, MEM_WAIT, HALTED} ctrl_state_e;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        is_out;
    logic        is_halt;
    logic        to_mem;
    logic        writes_rd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    // store address decode, the ALU computes rs1 + offset
    assign is_out    = (opcode == STORE) && (alu_result == OUT_ADDR);
    assign is_halt   = (opcode == STORE) && (alu_result == HALT_ADDR);
    assign to_mem    = (opcode == LOAD) || ((opcode == STORE) && !is_out);
    assign writes_rd = opcode inside {OPIMM, OP, LUI, AUIPC, JAL, JALR};

    assign capture     = (state == EXEC) && mem_ack;
    assign use_latched = (state == MEM_WAIT);
    assign halt        = (state == HALTED);

    assign wr_sel  = rd;
    assign wr_data = (opcode == LOAD) ? mem_rd_data :
                     (opcode == JAL || opcode == JALR) ? link_addr : alu_result;

    always_comb begin
        state_next  = state;
        mem_addr    = '0;
        mem_wr_data = '0;
        mem_rd_req  = 1'b0;
        mem_wr_req  = 1'b0;
        pc_load     = 1'b0;
        wr_en       = 1'b0;
        out         = '0;
        outen       = 1'b0;
        case (state)
            FETCH: begin
                // link_addr is pc + 4, so one word back is the reset pc
                mem_addr   = link_addr - ADDR_W'(4);
                // no request goes out while reset is held
                mem_rd_req = !rst;
                state_next = EXEC;
            end
            EXEC: begin
                if (mem_ack) begin
                    if (!imm_valid_op || is_halt) begin
                        state_next = HALTED;
                    end else if (to_mem) begin
                        mem_addr    = alu_result;
                        mem_rd_req  = (opcode == LOAD);
                        mem_wr_req  = (opcode == STORE);
                        mem_wr_data = (opcode == STORE) ? rs2_data : '0;
                        state_next  = MEM_WAIT;
                    end else begin
                        wr_en      = writes_rd;
                        outen      = is_out;
                        out        = is_out ? rs2_data : '0;
                        pc_load    = 1'b1;
                        mem_addr   = next_pc;
                        mem_rd_req = 1'b1;
                    end
                end
            end
            MEM_WAIT: begin
                if (mem_ack) begin
                    wr_en      = (opcode == LOAD);
                    pc_load    = 1'b1;
                    mem_addr   = next_pc;
                    mem_rd_req = 1'b1;
                    state_next = EXEC;
                end
            end
            HALTED: begin
                // stays here until reset
                state_next = HALTED;
            end
            default: state_next = HALTED;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
// Top level of the RV32I core. Connects decoder, register file, ALU and
// pc unit to the control FSM. Memory sits outside on a request and
// acknowledge port; results leave through out and outen.

`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter logic [rv_pkg::ADDR_W-1:0] RESET_PC  = '0,
    parameter logic [rv_pkg::ADDR_W-1:0] OUT_ADDR  = 32'd1000,
    parameter logic [rv_pkg::ADDR_W-1:0] HALT_ADDR = 32'd1004
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [rv_pkg::XLEN-1:0]   mem_rd_data,
    input  logic                      mem_ack,
    output logic [rv_pkg::ADDR_W-1:0] mem_addr,
    output logic [rv_pkg::XLEN-1:0]   mem_wr_data,
    output logic                      mem_rd_req,
    output logic                      mem_wr_req,
    output logic [rv_pkg::XLEN-1:0]   out,
    output logic                      outen,
    output logic                      halt
);
    import rv_pkg::*;

    opcode_e              opcode;
    alu_op_e              alu_op;
    logic [REG_SEL_W-1:0] rd;
    logic [REG_SEL_W-1:0] rs1;
    logic [REG_SEL_W-1:0] rs2;
    logic [2:0]           funct3;
    logic [XLEN-1:0]      imm;
    logic                 imm_valid_op;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic [XLEN-1:0]      op_a;
    logic [XLEN-1:0]      op_b;
    logic [XLEN-1:0]      alu_result;
    logic                 branch_taken;
    logic [ADDR_W-1:0]    pc;
    logic [ADDR_W-1:0]    next_pc;
    logic [ADDR_W-1:0]    link_addr;
    logic                 capture;
    logic                 use_latched;
    logic                 pc_load;
    logic                 wr_en;
    logic [REG_SEL_W-1:0] wr_sel;
    logic [XLEN-1:0]      wr_data;

    // AUIPC adds to the pc, OP and BRANCH work on two registers
    assign op_a = (opcode == AUIPC) ? pc : rs1_data;
    assign op_b = (opcode == OP || opcode == BRANCH) ? rs2_data : imm;

    rv_decode u_decode (
        .clk(clk), .rst(rst), .capture(capture), .mem_rd_data(mem_rd_data),
        .use_latched(use_latched), .opcode(opcode), .rd(rd), .rs1(rs1), .rs2(rs2),
        .funct3(funct3), .alu_op(alu_op), .imm(imm), .imm_valid_op(imm_valid_op)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst), .wr_en(wr_en), .wr_sel(wr_sel), .rs1_sel(rs1),
        .rs2_sel(rs2), .wr_data(wr_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_alu u_alu (
        .op(alu_op), .a(op_a), .b(op_b), .funct3(funct3),
        .result(alu_result), .branch_taken(branch_taken)
    );

    rv_pc_unit #(.RESET_PC(RESET_PC)) u_pc_unit (
        .clk(clk), .rst(rst), .pc_load(pc_load), .branch_taken(branch_taken),
        .opcode(opcode), .imm(imm), .rs1_data(rs1_data), .pc(pc),
        .next_pc(next_pc), .link_addr(link_addr)
    );

    rv_control #(.OUT_ADDR(OUT_ADDR), .HALT_ADDR(HALT_ADDR)) u_control (
        .clk(clk), .rst(rst), .mem_ack(mem_ack), .opcode(opcode),
        .imm_valid_op(imm_valid_op), .rd(rd), .alu_result(alu_result),
        .rs2_data(rs2_data), .mem_rd_data(mem_rd_data), .next_pc(next_pc),
        .link_addr(link_addr), .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req), .capture(capture),
        .use_latched(use_latched), .pc_load(pc_load), .wr_en(wr_en),
        .wr_sel(wr_sel), .wr_data(wr_data), .out(out), .outen(outen), .halt(halt)
    );

endmodule

`default_nettype wire

// ==== rtl/rv_decode.sv ====
// Instruction decoder with the instruction register.
// Decodes either the word arriving from memory or the word captured on
// the fetch acknowledge, so a load still knows its rd while it waits.

`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         capture,
    input  logic [rv_pkg::XLEN-1:0]      mem_rd_data,
    input  logic                         use_latched,
    output rv_pkg::opcode_e              opcode,
    output logic [rv_pkg::REG_SEL_W-1:0] rd,
    output logic [rv_pkg::REG_SEL_W-1:0] rs1,
    output logic [rv_pkg::REG_SEL_W-1:0] rs2,
    output logic [2:0]                   funct3,
    output rv_pkg::alu_op_e              alu_op,
    output logic [rv_pkg::XLEN-1:0]      imm,
    output logic                         imm_valid_op
);
    import rv_pkg::*;

    logic [XLEN-1:0] instr_q;
    logic [XLEN-1:0] instr;
    logic            alt;

    // funct3 to ALU operation, alt picks SUB or SRA
    function automatic alu_op_e funct_to_op(input logic [2:0] f3, input logic alt_sel);
        case (f3)
            F3_ADD:  return alt_sel ? SUB : ADD;
            F3_SLL:  return SLL;
            F3_SLT:  return SLT;
            F3_SLTU: return SLTU;
            F3_XOR:  return XOR;
            F3_SR:   return alt_sel ? SRA : SRL;
            F3_OR:   return OR;
            default: return AND;
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr_q <= '0;
        end else if (capture) begin
            instr_q <= mem_rd_data;
        end
    end

    assign instr  = use_latched ? instr_q : mem_rd_data;
    assign opcode = opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign alt    = instr[30];

    always_comb begin
        alu_op       = ADD;
        imm          = '0;
        imm_valid_op = 1'b1;
        case (opcode)
            OPIMM: begin
                imm = imm_i(instr);
                // bit 30 only means SRAI here, addi has no subtract form
                alu_op = funct_to_op(funct3, alt && (funct3 == F3_SR));
            end
            OP:     alu_op = funct_to_op(funct3, alt);
            LOAD:   imm = imm_i(instr);
            JALR:   imm = imm_i(instr);
            STORE:  imm = imm_s(instr);
            BRANCH: imm = imm_b(instr);
            JAL:    imm = imm_j(instr);
            AUIPC:  imm = imm_u(instr);
            LUI: begin
                imm    = imm_u(instr);
                alu_op = PASS_B;
            end
            default: imm_valid_op = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_pc_unit.sv ====
// Program counter and next-pc logic.
// next_pc is pc + 4, a pc-relative branch or JAL target, or the JALR
// target; the pc takes it on the edge after pc_load.

`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit #(
    parameter logic [rv_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pc_load,
    input  logic                      branch_taken,
    input  rv_pkg::opcode_e           opcode,
    input  logic [rv_pkg::XLEN-1:0]   imm,
    input  logic [rv_pkg::XLEN-1:0]   rs1_data,
    output logic [rv_pkg::ADDR_W-1:0] pc,
    output logic [rv_pkg::ADDR_W-1:0] next_pc,
    output logic [rv_pkg::ADDR_W-1:0] link_addr
);
    import rv_pkg::*;

    logic [ADDR_W-1:0] rel_target;
    logic [ADDR_W-1:0] jalr_sum;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

    assign link_addr  = pc + ADDR_W'(4);
    assign rel_target = pc + imm;
    assign jalr_sum   = rs1_data + imm;

    always_comb begin
        case (opcode)
            JAL:     next_pc = rel_target;
            BRANCH:  next_pc = branch_taken ? rel_target : link_addr;
            JALR:    next_pc = {jalr_sum[ADDR_W-1:1], 1'b0};
            default: next_pc = link_addr;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_pkg.sv ====
// Shared definitions for the RV32I multi-cycle core.
// Widths, opcode and ALU operation enums, funct3 names and the
// immediate builders used by the decoder.

`default_nettype none

package rv_pkg;

    localparam int XLEN      = 32;
    localparam int ADDR_W    = 32;
    localparam int REG_SEL_W = 5;
    localparam int NUM_REGS  = 32;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        LOAD   = 7'h03,
        OPIMM  = 7'h13,
        AUIPC  = 7'h17,
        STORE  = 7'h23,
        OP     = 7'h33,
        LUI    = 7'h37,
        BRANCH = 7'h63,
        JALR   = 7'h67,
        JAL    = 7'h6f
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_e;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'd0;
    localparam logic [2:0] F3_BNE  = 3'd1;
    localparam logic [2:0] F3_BLT  = 3'd4;
    localparam logic [2:0] F3_BGE  = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;
    localparam logic [2:0] F3_BGEU = 3'd7;

    // immediate and register ops
    localparam logic [2:0] F3_ADD  = 3'd0;
    localparam logic [2:0] F3_SLL  = 3'd1;
    localparam logic [2:0] F3_SLT  = 3'd2;
    localparam logic [2:0] F3_SLTU = 3'd3;
    localparam logic [2:0] F3_XOR  = 3'd4;
    localparam logic [2:0] F3_SR   = 3'd5;
    localparam logic [2:0] F3_OR   = 3'd6;
    localparam logic [2:0] F3_AND  = 3'd7;

    function automatic logic [XLEN-1:0] imm_i(input logic [XLEN-1:0] instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic logic [XLEN-1:0] imm_s(input logic [XLEN-1:0] instr);
        return {{20{instr[31]}}, instr[31:25], instr[11:7]};
    endfunction

    function automatic logic [XLEN-1:0] imm_b(input logic [XLEN-1:0] instr);
        return {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] imm_u(input logic [XLEN-1:0] instr);
        return {instr[31:12], 12'h000};
    endfunction

    function automatic logic [XLEN-1:0] imm_j(input logic [XLEN-1:0] instr);
        return {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
// Integer register file, two combinational read ports and one
// write port that updates on the clock edge. x0 always reads zero.

`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr_en,
    input  logic [rv_pkg::REG_SEL_W-1:0] wr_sel,
    input  logic [rv_pkg::REG_SEL_W-1:0] rs1_sel,
    input  logic [rv_pkg::REG_SEL_W-1:0] rs2_sel,
    input  logic [rv_pkg::XLEN-1:0]      wr_data,
    output logic [rv_pkg::XLEN-1:0]      rs1_data,
    output logic [rv_pkg::XLEN-1:0]      rs2_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_sel != '0)) begin
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

endmodule

`default_nettype wire

// ==== tb/rv_core_assert.sv ====
// Memory port and halt protocol assertions, bound into rv_core.

`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
    input logic clk,
    input logic rst,
    input logic mem_rd_req,
    input logic mem_wr_req,
    input logic outen,
    input logic halt
);

    // failures seen so far, read by the testbench at the end
    int fail_count = 0;

    // one request kind at a time
    a_one_req: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req && mem_wr_req))
        else begin
            $error("read and write request high together");
            fail_count++;
        end

    a_quiet_halt: assert property (@(posedge clk) disable iff (rst)
        halt |-> !(mem_rd_req || mem_wr_req || outen))
        else begin
            $error("request or outen while halted");
            fail_count++;
        end

    // halt only leaves through reset
    a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
        halt |=> halt)
        else begin
            $error("halt dropped without reset");
            fail_count++;
        end

endmodule

bind rv_core rv_core_assert u_assert (
    .clk(clk), .rst(rst), .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req),
    .outen(outen), .halt(halt)
);

`default_nettype wire

// ==== tb/rv_core_tb.sv ====
// Testbench for the RV32I core. Loads program, data and expected
// outputs from tb/rv_golden.hex, serves memory with random latency,
// checks every outen value in order, memory contents and the halt.

`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    localparam logic [ADDR_W-1:0] RESET_PC  = 32'd0;
    localparam logic [ADDR_W-1:0] OUT_ADDR  = 32'd1000;
    localparam logic [ADDR_W-1:0] HALT_ADDR = 32'd1004;
    localparam int MEM_WORDS = 256;

    logic              clk = 1'b0;
    logic              rst;
    logic [XLEN-1:0]   mem_rd_data;
    logic              mem_ack;
    logic [ADDR_W-1:0] mem_addr;
    logic [XLEN-1:0]   mem_wr_data;
    logic              mem_rd_req;
    logic              mem_wr_req;
    logic [XLEN-1:0]   out;
    logic              outen;
    logic              halt;

    logic [XLEN-1:0]   mem [MEM_WORDS];
    logic [XLEN-1:0]   exp_out [$];
    logic [ADDR_W-1:0] exp_mem_addr [$];
    logic [XLEN-1:0]   exp_mem_data [$];

    int          prog_words = 0;
    int          out_count = 0;
    int          out_errors = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          halt_reqs = 0;
    logic        busy = 1'b0;
    int          wait_cnt = 0;
    logic [ADDR_W-1:0] pend_addr;

    rv_core #(
        .RESET_PC(RESET_PC), .OUT_ADDR(OUT_ADDR), .HALT_ADDR(HALT_ADDR)
    ) UUT (
        .clk(clk), .rst(rst), .mem_rd_data(mem_rd_data), .mem_ack(mem_ack),
        .mem_addr(mem_addr), .mem_wr_data(mem_wr_data), .mem_rd_req(mem_rd_req),
        .mem_wr_req(mem_wr_req), .out(out), .outen(outen), .halt(halt)
    );

    always #2 clk = ~clk;

    // background pattern, every word tells its own address
    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5A000000 | (i << 2);
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    n;
        string line;
        string tag;
        logic [31:0] col_a;
        logic [31:0] col_b;
        fd = $fopen("tb/rv_golden.hex", "r");
        if (fd == 0) begin
            $display("could not open tb/rv_golden.hex");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %h %h", tag, col_a, col_b);
                if (n == 3) begin
                    case (tag)
                        "P": begin
                            mem[col_a[9:2]] = col_b;
                            prog_words++;
                        end
                        "D": mem[col_a[9:2]] = col_b;
                        "E": exp_out.push_back(col_b);
                        "M": begin
                            exp_mem_addr.push_back(col_a);
                            exp_mem_data.push_back(col_b);
                        end
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic respond(input logic [ADDR_W-1:0] addr);
        mem_ack     <= 1'b1;
        mem_rd_data <= mem[addr[9:2]];
    endtask

    // memory model, one request at a time, ack after 1 to 3 cycles
    initial begin : mem_model
        int lat;
        void'($urandom(32'h4976));
        forever begin
            @(posedge clk);
            mem_ack <= 1'b0;
            if (!rst) begin
                if (busy) begin
                    if (wait_cnt == 0) begin
                        respond(pend_addr);
                        busy <= 1'b0;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                if (mem_rd_req || mem_wr_req) begin
                    lat = 1 + int'($urandom % 3);
                    checks++;
                    assert (mem_addr < MEM_WORDS * 4) else begin
                        $display("** Error at %0t: request address %h outside memory",
                                 $time, mem_addr);
                        errors++;
                    end
                    if (mem_wr_req) begin
                        mem[mem_addr[9:2]] <= mem_wr_data;
                    end
                    if (lat == 1) begin
                        respond(mem_addr);
                    end else begin
                        busy      <= 1'b1;
                        wait_cnt  <= lat - 2;
                        pend_addr <= mem_addr;
                    end
                end
            end
        end
    end

    // output strobe and halt monitor
    always @(posedge clk) begin
        if (!rst && outen) begin
            checks++;
            if (out_count < exp_out.size()) begin
                assert (out == exp_out[out_count]) else begin
                    $display("** Error at %0t: output %0d is %h, expected %h",
                             $time, out_count, out, exp_out[out_count]);
                    errors++;
                    out_errors++;
                end
            end else begin
                $display("output %0d with value %h is more than expected", out_count, out);
                errors++;
                out_errors++;
            end
            out_count++;
        end
        if (!rst && halt && (mem_rd_req || mem_wr_req || outen)) begin
            halt_reqs++;
        end
    end

    // run limit from the program length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("run timed out after %0d cycles before the core halted", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int err_before;
        rst         = 1'b1;
        mem_ack     = 1'b0;
        mem_rd_data = '0;
        fill_memory();
        load_golden();
        timeout_limit = 3 * (prog_words * 4 + 16) * 3;

        repeat (2) @(posedge clk);

        // nothing may leave the core while reset is held
        err_before = errors;
        checks++;
        assert (!halt && !outen && !mem_rd_req && !mem_wr_req) else begin
            $display("** Error at %0t: halt, outen or a request high during reset", $time);
            errors++;
        end
        rst <= 1'b0;

        // first cycle out of reset is the fetch of the reset pc
        @(posedge clk);
        checks++;
        assert (!halt && !outen && !mem_wr_req) else begin
            $display("** Error at %0t: halt, outen or mem_wr_req high after reset", $time);
            errors++;
        end
        checks++;
        assert (mem_rd_req && mem_addr == RESET_PC) else begin
            $display("** Error at %0t: first fetch req %b addr %h, expected addr %h",
                     $time, mem_rd_req, mem_addr, RESET_PC);
            errors++;
        end
        $display("test reset and first fetch: %s", (errors == err_before) ? "ok" : "failed");

        while (!halt) begin
            @(posedge clk);
        end
        repeat (16) @(posedge clk);

        $display("test output sequence: %0d outputs, %0d expected, %0d wrong",
                 out_count, exp_out.size(), out_errors);

        err_before = errors;
        foreach (exp_mem_addr[i]) begin
            checks++;
            assert (mem[exp_mem_addr[i][9:2]] == exp_mem_data[i]) else begin
                $display("** Error at %0t: memory %h holds %h, expected %h", $time,
                         exp_mem_addr[i], mem[exp_mem_addr[i][9:2]], exp_mem_data[i]);
                errors++;
            end
        end
        $display("test stored words: %s", (errors == err_before) ? "ok" : "failed");

        err_before = errors;
        checks++;
        assert (halt) else begin
            $display("** Error at %0t: halt dropped after it was raised", $time);
            errors++;
        end
        checks++;
        assert (halt_reqs == 0) else begin
            $display("** Error at %0t: %0d requests or strobes while halted", $time, halt_reqs);
            errors++;
        end
        checks++;
        assert (out_count == exp_out.size()) else begin
            $display("** Error at %0t: %0d outputs seen, %0d expected",
                     $time, out_count, exp_out.size());
            errors++;
        end
        $display("test halt: %s", (errors == err_before) ? "ok" : "failed");

        err_before = errors;
        checks++;
        assert (UUT.u_assert.fail_count == 0) else begin
            $display("the bound protocol assertions failed %0d times",
                     UUT.u_assert.fail_count);
            errors++;
        end
        $display("test protocol: %s", (errors == err_before) ? "ok" : "failed");

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/rv_golden.hex ====
// tag addr value: P program word, D initial data word, M memory word after the run
// tag index value: E expected out value in order
P 00000000 00500093
P 00000004 3E102423
P 00000008 FFD00113
P 0000000C 002081B3
P 00000010 3E302423
P 00000014 40208233
P 00000018 3E402423
P 0000001C 001122B3
P 00000020 3E502423
P 00000024 00113333
P 00000028 3E602423
P 0000002C 40115393
P 00000030 3E702423
P 00000034 00415413
P 00000038 3E802423
P 0000003C FFE12493
P 00000040 3E902423
P 00000044 12345537
P 00000048 0F054513
P 0000004C 3EA02423
P 00000050 00001597
P 00000054 3EB02423
P 00000058 00309613
P 0000005C 3EC02423
P 00000060 20000693
P 00000064 00A6A223
P 00000068 0046A703
P 0000006C 3EE02423
P 00000070 0006A783
P 00000074 3EF02423
P 00000078 0076A423
P 0000007C 00114463
P 00000080 3E102423
P 00000084 00116463
P 00000088 3E302423
P 0000008C 0020D463
P 00000090 3E102423
P 00000094 00208463
P 00000098 3E402423
P 0000009C 00209463
P 000000A0 3E102423
P 000000A4 0020F463
P 000000A8 3E502423
P 000000AC 00C008EF
P 000000B0 3E102423
P 000000B4 3E102423
P 000000B8 3F102423
P 000000BC 0CC00993
P 000000C0 00198967
P 000000C4 3E102423
P 000000C8 3E102423
P 000000CC 3F202423
P 000000D0 3E002623
D 00000200 CAFEF00D
E 00 00000005
E 01 00000002
E 02 00000008
E 03 00000001
E 04 00000000
E 05 FFFFFFFE
E 06 0FFFFFFF
E 07 00000001
E 08 123450F0
E 09 00001050
E 0A 00000028
E 0B 123450F0
E 0C CAFEF00D
E 0D 00000002
E 0E 00000008
E 0F 00000001
E 10 000000B0
E 11 000000C4
M 00000200 CAFEF00D
M 00000204 123450F0
M 00000208 FFFFFFFE
